// File: rtl/touch_tft_pkg.sv
package touch_tft_pkg;

	// panel geometry in pixel clocks and lines
	localparam int H_ACTIVE = 480;
	localparam int H_BLANK  = 45;
	localparam int H_TOTAL  = H_ACTIVE + H_BLANK;
	localparam int V_ACTIVE = 272;
	localparam int V_BLANK  = 16;
	localparam int V_TOTAL  = V_ACTIVE + V_BLANK;

	// touch link
	localparam int COORD_W       = 12;
	localparam int TOUCH_CLK_DIV = 8;
	// start bit, channel select, 12 bit, differential, power down between conversions
	localparam logic [7:0] CMD_X = 8'hD0;
	localparam logic [7:0] CMD_Y = 8'h90;
	localparam logic [7:0] CMD_Z = 8'hB0;

	typedef logic [9:0] px_t;
	typedef logic [8:0] py_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// apb register offsets
	localparam logic [7:0] REG_CTRL      = 8'h00;
	localparam logic [7:0] REG_BACKLIGHT = 8'h04;
	localparam logic [7:0] REG_CURSOR    = 8'h08;
	localparam logic [7:0] REG_BG        = 8'h0C;
	localparam logic [7:0] REG_THRESH    = 8'h10;
	localparam logic [7:0] REG_STATUS    = 8'h14;

	// register reset values
	localparam logic               RST_DISPLAY_EN = 1'b1;
	localparam logic [7:0]         RST_DUTY       = 8'h80;
	localparam rgb_t               RST_CURSOR     = 24'hFFFFFF;
	localparam rgb_t               RST_BG         = 24'h000000;
	localparam logic [COORD_W-1:0] RST_THRESH     = 12'd512;

endpackage

// File: rtl/touch_sample_if.sv
interface touch_sample_if;

	// one pulse per completed x/y/z triple
	logic valid;
	// held from valid until the next valid
	logic [touch_tft_pkg::COORD_W-1:0] x;
	logic [touch_tft_pkg::COORD_W-1:0] y;
	logic [touch_tft_pkg::COORD_W-1:0] z;

	// touch controller side
	modport src (
		output valid, x, y, z
	);

	// compositor and register side, always ready
	modport sink (
		input valid, x, y, z
	);

endinterface

// File: rtl/touchpad_controller.sv
module touchpad_controller (
	input  logic cclk,
	input  logic reset,
	input  logic touch_busy,
	input  logic touch_data_out,
	output logic touch_clk,
	output logic touch_csb,
	output logic touch_data_in,
	touch_sample_if.src sample
);

	localparam int CW = touch_tft_pkg::COORD_W;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_WAIT,
		ST_READ,
		ST_PAD
	} state_t;

	state_t state;
	logic [$clog2(touch_tft_pkg::TOUCH_CLK_DIV)-1:0] div_cnt;
	logic [3:0] cnt;
	logic [1:0] conv;
	logic [7:0] cmd_sr;
	logic [CW-1:0] data_sr;
	logic [CW-1:0] x_acc;
	logic [CW-1:0] y_acc;
	logic [7:0] cmd_byte;
	logic [CW-1:0] word;
	logic tick, rise, fall;
	logic start_conv, cmd_fall, sample_bit, read_done;

	// touch_clk edges, one cclk ahead of the toggle
	assign tick = (div_cnt == ($bits(div_cnt))'(touch_tft_pkg::TOUCH_CLK_DIV - 1));
	assign rise = tick && !touch_clk;
	assign fall = tick && touch_clk;

	// conversion order x, y, z
	always_comb begin
		case (conv)
			2'd0: cmd_byte = touch_tft_pkg::CMD_X;
			2'd1: cmd_byte = touch_tft_pkg::CMD_Y;
			default: cmd_byte = touch_tft_pkg::CMD_Z;
		endcase
	end

	// csb gap of two periods done
	assign start_conv = (state == ST_IDLE) && fall && (cnt == 4'd1);
	assign cmd_fall   = (state == ST_CMD) && fall;
	// first data bit comes with busy low
	assign sample_bit = ((state == ST_WAIT) && rise && !touch_busy) ||
		((state == ST_READ) && rise);
	assign read_done  = (state == ST_READ) && rise && (cnt == 4'(CW - 1));
	assign word       = {data_sr[CW-2:0], touch_data_out};

	always_ff @(posedge cclk) begin
		if (reset) begin
			div_cnt <= '0;
			touch_clk <= 1'b1;
			touch_csb <= 1'b1;
			touch_data_in <= 1'b0;
			state <= ST_IDLE;
			cnt <= '0;
			conv <= '0;
			sample.valid <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				touch_clk <= ~touch_clk;
			sample.valid <= read_done && (conv == 2'd2);
			case (state)
				ST_IDLE: begin
					if (start_conv) begin
						state <= ST_CMD;
						touch_csb <= 1'b0;
						touch_data_in <= cmd_byte[7];
						cnt <= '0;
					end else if (fall) begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_CMD: begin
					// msb first, changes on falling edge
					if (cmd_fall) begin
						if (cnt == 4'd7) begin
							state <= ST_WAIT;
							touch_data_in <= 1'b0;
						end else begin
							touch_data_in <= cmd_sr[6];
							cnt <= cnt + 1'b1;
						end
					end
				end
				ST_WAIT: begin
					if (sample_bit) begin
						state <= ST_READ;
						cnt <= 4'd1;
					end
				end
				ST_READ: begin
					if (read_done) begin
						state <= ST_PAD;
						cnt <= '0;
						conv <= (conv == 2'd2) ? 2'd0 : conv + 1'b1;
					end else if (rise) begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_PAD: begin
					// four padding clocks then release csb
					if (fall) begin
						if (cnt == 4'd4) begin
							state <= ST_IDLE;
							touch_csb <= 1'b1;
							cnt <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shift registers and results
	always_ff @(posedge cclk) begin
		if (start_conv)
			cmd_sr <= cmd_byte;
		else if (cmd_fall)
			cmd_sr <= {cmd_sr[6:0], 1'b0};
		if (sample_bit)
			data_sr <= word;
		if (read_done) begin
			case (conv)
				2'd0: x_acc <= word;
				2'd1: y_acc <= word;
				default: begin
					// publish the whole triple together
					sample.x <= x_acc;
					sample.y <= y_acc;
					sample.z <= word;
				end
			endcase
		end
	end

endmodule

// File: rtl/tft_timing.sv
module tft_timing (
	input  logic cclk,
	input  logic reset,
	input  logic display_en,
	output touch_tft_pkg::px_t x,
	output touch_tft_pkg::py_t y,
	output logic active,
	output logic new_frame
);

	touch_tft_pkg::px_t h_cnt;
	touch_tft_pkg::py_t v_cnt;
	logic h_last;
	logic v_last;
	logic h_vis;
	logic v_vis;

	// end of line and end of frame
	assign h_last = (h_cnt == touch_tft_pkg::px_t'(touch_tft_pkg::H_TOTAL - 1));
	assign v_last = (v_cnt == touch_tft_pkg::py_t'(touch_tft_pkg::V_TOTAL - 1));

	// column counter, one pixel per cclk
	always_ff @(posedge cclk) begin
		if (reset) begin
			h_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// line counter steps at end of each line
	always_ff @(posedge cclk) begin
		if (reset) begin
			v_cnt <= '0;
		end else if (h_last) begin
			if (v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end
	end

	// visible window
	assign h_vis = (h_cnt < touch_tft_pkg::px_t'(touch_tft_pkg::H_ACTIVE));
	assign v_vis = (v_cnt < touch_tft_pkg::py_t'(touch_tft_pkg::V_ACTIVE));

	// counters keep running when disabled so frames stay aligned
	assign active = h_vis && v_vis && display_en;

	// top left pixel
	assign new_frame = (h_cnt == '0) && (v_cnt == '0);

	assign x = h_cnt;
	assign y = v_cnt;

endmodule

// File: rtl/cursor_compositor.sv
module cursor_compositor (
	input  logic cclk,
	input  logic reset,
	input  touch_tft_pkg::px_t x,
	input  touch_tft_pkg::py_t y,
	input  logic active,
	input  logic new_frame,
	touch_sample_if.sink sample,
	input  logic [touch_tft_pkg::COORD_W-1:0] threshold,
	input  touch_tft_pkg::rgb_t cursor_color,
	input  touch_tft_pkg::rgb_t bg_color,
	output logic tft_data_ena,
	output logic [7:0] tft_red,
	output logic [7:0] tft_green,
	output logic [7:0] tft_blue
);

	localparam int CW = touch_tft_pkg::COORD_W;

	logic have_sample;
	logic [CW-1:0] lx, ly, lz;
	logic touched;
	touch_tft_pkg::px_t scaled_x;
	touch_tft_pkg::py_t scaled_y;
	touch_tft_pkg::px_t cur_x, cur_x_nxt;
	touch_tft_pkg::py_t cur_y, cur_y_nxt;
	logic on_cursor;
	touch_tft_pkg::rgb_t pix;

	// newest sample from the touch controller
	always_ff @(posedge cclk) begin
		if (reset)
			have_sample <= 1'b0;
		else if (sample.valid)
			have_sample <= 1'b1;
	end

	always_ff @(posedge cclk) begin
		if (sample.valid) begin
			lx <= sample.x;
			ly <= sample.y;
			lz <= sample.z;
		end
	end

	// pressure check
	assign touched = have_sample && (lz >= threshold);

	// raw to panel coordinates, x clamped to last column
	always_comb begin
		scaled_x = touch_tft_pkg::px_t'(lx >> 2);
		if (scaled_x > touch_tft_pkg::px_t'(touch_tft_pkg::H_ACTIVE - 1))
			scaled_x = touch_tft_pkg::px_t'(touch_tft_pkg::H_ACTIVE - 1);
		scaled_y = touch_tft_pkg::py_t'(ly >> 4);
	end

	// bypass so the new position already applies to pixel 0,0
	assign cur_x_nxt = (new_frame && touched) ? scaled_x : cur_x;
	assign cur_y_nxt = (new_frame && touched) ? scaled_y : cur_y;

	always_ff @(posedge cclk) begin
		if (reset) begin
			cur_x <= '0;
			cur_y <= '0;
		end else begin
			cur_x <= cur_x_nxt;
			cur_y <= cur_y_nxt;
		end
	end

	// crosshair is the full cursor column plus the full cursor row
	assign on_cursor = (x == cur_x_nxt) || (y == cur_y_nxt);
	assign pix = on_cursor ? cursor_color : bg_color;

	// one cycle pixel pipeline, black outside the active area
	always_ff @(posedge cclk) begin
		if (reset) begin
			tft_data_ena <= 1'b0;
			tft_red <= '0;
			tft_green <= '0;
			tft_blue <= '0;
		end else begin
			tft_data_ena <= active;
			tft_red <= active ? pix.red : 8'h00;
			tft_green <= active ? pix.green : 8'h00;
			tft_blue <= active ? pix.blue : 8'h00;
		end
	end

endmodule

// File: rtl/tft_ctrl_regs.sv
module tft_ctrl_regs (
	input  logic cclk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	touch_sample_if.sink sample,
	output logic display_en,
	output touch_tft_pkg::rgb_t cursor_color,
	output touch_tft_pkg::rgb_t bg_color,
	output logic [touch_tft_pkg::COORD_W-1:0] threshold,
	output logic tft_backlight
);

	localparam int CW = touch_tft_pkg::COORD_W;

	logic [7:0] duty;
	logic sample_seen;
	logic [CW-1:0] last_x, last_y;
	logic [7:0] pwm_cnt;
	logic mapped;
	logic wr_en;

	// access phase only, no wait states
	assign pready = 1'b1;
	assign wr_en = psel && penable && pwrite && mapped;
	assign pslverr = psel && penable && !mapped;

	// read mux and address decode
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			touch_tft_pkg::REG_CTRL:      prdata = 32'(display_en);
			touch_tft_pkg::REG_BACKLIGHT: prdata = 32'(duty);
			touch_tft_pkg::REG_CURSOR:    prdata = 32'(cursor_color);
			touch_tft_pkg::REG_BG:        prdata = 32'(bg_color);
			touch_tft_pkg::REG_THRESH:    prdata = 32'(threshold);
			touch_tft_pkg::REG_STATUS:    prdata = {7'b0, sample_seen, last_x, last_y};
			default:                      mapped = 1'b0;
		endcase
	end

	// config registers, status writes dropped silently
	always_ff @(posedge cclk) begin
		if (reset) begin
			display_en <= touch_tft_pkg::RST_DISPLAY_EN;
			duty <= touch_tft_pkg::RST_DUTY;
			cursor_color <= touch_tft_pkg::RST_CURSOR;
			bg_color <= touch_tft_pkg::RST_BG;
			threshold <= touch_tft_pkg::RST_THRESH;
		end else if (wr_en) begin
			case (paddr)
				touch_tft_pkg::REG_CTRL:      display_en <= pwdata[0];
				touch_tft_pkg::REG_BACKLIGHT: duty <= pwdata[7:0];
				touch_tft_pkg::REG_CURSOR:    cursor_color <= pwdata[23:0];
				touch_tft_pkg::REG_BG:        bg_color <= pwdata[23:0];
				touch_tft_pkg::REG_THRESH:    threshold <= pwdata[CW-1:0];
				default: ;
			endcase
		end
	end

	// last touch sample
	always_ff @(posedge cclk) begin
		if (reset) begin
			sample_seen <= 1'b0;
			last_x <= '0;
			last_y <= '0;
		end else if (sample.valid) begin
			sample_seen <= 1'b1;
			last_x <= sample.x;
			last_y <= sample.y;
		end
	end

	// backlight pwm, 256 cclk period
	always_ff @(posedge cclk) begin
		if (reset) begin
			pwm_cnt <= '0;
			tft_backlight <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			tft_backlight <= (pwm_cnt < duty);
		end
	end

endmodule

// File: rtl/touch_tft_top.sv
module touch_tft_top (
	input  logic cclk,
	input  logic reset,
	// apb
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// touch device
	input  logic touch_busy,
	input  logic touch_data_out,
	output logic touch_clk,
	output logic touch_csb,
	output logic touch_data_in,
	// panel
	output logic tft_backlight,
	output logic tft_display,
	output logic tft_vdd,
	output logic tft_data_ena,
	output logic [7:0] tft_red,
	output logic [7:0] tft_green,
	output logic [7:0] tft_blue
);

	touch_sample_if touch_sample ();

	touch_tft_pkg::px_t tft_x;
	touch_tft_pkg::py_t tft_y;
	logic tft_active;
	logic tft_new_frame;
	logic display_en;
	touch_tft_pkg::rgb_t cursor_color;
	touch_tft_pkg::rgb_t bg_color;
	logic [touch_tft_pkg::COORD_W-1:0] threshold;

	// panel power follows the display enable
	assign tft_display = display_en;
	assign tft_vdd = display_en;

	touchpad_controller u_touch (
		.cclk(cclk),
		.reset(reset),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.sample(touch_sample.src)
	);

	tft_timing u_timing (
		.cclk(cclk),
		.reset(reset),
		.display_en(display_en),
		.x(tft_x),
		.y(tft_y),
		.active(tft_active),
		.new_frame(tft_new_frame)
	);

	cursor_compositor u_comp (
		.cclk(cclk),
		.reset(reset),
		.x(tft_x),
		.y(tft_y),
		.active(tft_active),
		.new_frame(tft_new_frame),
		.sample(touch_sample.sink),
		.threshold(threshold),
		.cursor_color(cursor_color),
		.bg_color(bg_color),
		.tft_data_ena(tft_data_ena),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue)
	);

	tft_ctrl_regs u_regs (
		.cclk(cclk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sample(touch_sample.sink),
		.display_en(display_en),
		.cursor_color(cursor_color),
		.bg_color(bg_color),
		.threshold(threshold),
		.tft_backlight(tft_backlight)
	);

endmodule

// File: dv/touch_panel_model.sv
module touch_panel_model (
	input  logic touch_clk,
	input  logic touch_csb,
	input  logic touch_data_in,
	output logic touch_busy,
	output logic touch_data_out,
	input  logic [touch_tft_pkg::COORD_W-1:0] x_val,
	input  logic [touch_tft_pkg::COORD_W-1:0] y_val,
	input  logic [touch_tft_pkg::COORD_W-1:0] z_val
);

	timeunit 1ns;
	timeprecision 100ps;

	// command byte as received, msb first
	logic [7:0] cmd;
	logic [3:0] cmd_bits;
	// falling edges since the command completed
	logic [4:0] stage;
	logic [touch_tft_pkg::COORD_W-1:0] out_sr;

	// channel select bits a2..a0 of the command
	function automatic logic [touch_tft_pkg::COORD_W-1:0] channel_value(input logic [7:0] c);
		case (c[6:4])
			3'b101: return x_val;
			3'b001: return y_val;
			3'b011: return z_val;
			default: return '0;
		endcase
	endfunction

	initial begin
		touch_busy <= 1'b0;
		touch_data_out <= 1'b0;
		cmd <= '0;
		cmd_bits <= '0;
		stage <= '0;
		out_sr <= '0;
	end

	// command bits are stable at the rising edge
	always @(posedge touch_clk) begin
		if (touch_csb) begin
			cmd_bits <= '0;
		end else if (cmd_bits < 4'd8) begin
			cmd <= {cmd[6:0], touch_data_in};
			cmd_bits <= cmd_bits + 1'b1;
		end
	end

	// busy for one period, then 12 result bits on falling edges
	always @(negedge touch_clk) begin
		if (touch_csb) begin
			stage <= '0;
			touch_busy <= 1'b0;
			touch_data_out <= 1'b0;
		end else if (cmd_bits == 4'd8) begin
			if (stage == 5'd0) begin
				touch_busy <= 1'b1;
				out_sr <= channel_value(cmd);
			end else if (stage <= 5'd12) begin
				touch_busy <= 1'b0;
				touch_data_out <= out_sr[touch_tft_pkg::COORD_W-1];
				out_sr <= {out_sr[touch_tft_pkg::COORD_W-2:0], 1'b0};
			end else begin
				// padding clocks
				touch_data_out <= 1'b0;
			end
			if (stage != 5'd31)
				stage <= stage + 1'b1;
		end
	end

endmodule

// File: dv/tb_touch_tft.sv
module tb_touch_tft;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 1500000;
	localparam logic [23:0] CURSOR_RGB = 24'h12_34_56;
	localparam logic [23:0] BG_RGB = 24'h0A_0B_0C;
	// pen down, pressure above the default threshold
	localparam logic [touch_tft_pkg::COORD_W-1:0] TOUCH_X = 12'h3A4;
	localparam logic [touch_tft_pkg::COORD_W-1:0] TOUCH_Y = 12'h8C0;
	localparam logic [touch_tft_pkg::COORD_W-1:0] TOUCH_Z = 12'h700;
	// pen moved with light pressure
	localparam logic [touch_tft_pkg::COORD_W-1:0] MOVED_X = 12'h800;
	localparam logic [touch_tft_pkg::COORD_W-1:0] MOVED_Y = 12'h400;
	localparam logic [touch_tft_pkg::COORD_W-1:0] LIGHT_Z = 12'h100;

	logic cclk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic touch_busy;
	logic touch_data_out;
	logic touch_clk;
	logic touch_csb;
	logic touch_data_in;
	logic tft_backlight;
	logic tft_display;
	logic tft_vdd;
	logic tft_data_ena;
	logic [7:0] tft_red;
	logic [7:0] tft_green;
	logic [7:0] tft_blue;
	logic [touch_tft_pkg::COORD_W-1:0] x_val;
	logic [touch_tft_pkg::COORD_W-1:0] y_val;
	logic [touch_tft_pkg::COORD_W-1:0] z_val;

	int errors;
	int checks;
	int tests_run;
	int cycle_cnt;

	touch_tft_top u_dut (
		.cclk(cclk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.tft_backlight(tft_backlight),
		.tft_display(tft_display),
		.tft_vdd(tft_vdd),
		.tft_data_ena(tft_data_ena),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue)
	);

	touch_panel_model u_panel (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.x_val(x_val),
		.y_val(y_val),
		.z_val(z_val)
	);

	// 4 ns pixel clock
	initial begin
		cclk = 1'b0;
		forever #2 cclk = ~cclk;
	end

	// watchdog, about ten frames
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge cclk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// wrong value, reported with time
	task automatic expect_true(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("ERR %0t %s", $time, msg);
			errors++;
		end
	endtask

	// something that never happened
	task automatic expect_reached(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		$display("%s: %0d errors", name, errors - errs_before);
	endtask

	// apb write, setup then access phase, pready always high
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge cclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge cclk);
		penable <= 1'b1;
		@(negedge cclk);
		err = pslverr;
		@(posedge cclk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge cclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge cclk);
		penable <= 1'b1;
		@(negedge cclk);
		data = prdata;
		err = pslverr;
		@(posedge cclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_cfg(input logic [7:0] addr, input logic [31:0] data);
		logic err;
		write_reg(addr, data, err);
		expect_true(!err, $sformatf("pslverr on write to offset %h", addr));
	endtask

	task automatic read_compare(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] data;
		logic err;
		read_reg(addr, data, err);
		expect_true(!err && data == exp,
			$sformatf("%s: read %h err %b, expected %h", name, data, err, exp));
	endtask

	// scaling rule: column x/4 clamped to 479, row y/16
	function automatic int expected_column(input logic [touch_tft_pkg::COORD_W-1:0] raw);
		int c;
		c = int'(raw) >> 2;
		if (c > 479)
			c = 479;
		return c;
	endfunction

	function automatic int expected_row(input logic [touch_tft_pkg::COORD_W-1:0] raw);
		return int'(raw) >> 4;
	endfunction

	// sampled at falling edges, ends on the first differing sample
	task automatic count_level(input logic level, output int len);
		len = 0;
		while (tft_data_ena == level) begin
			len++;
			@(negedge cclk);
		end
	endtask

	// returns on pixel 0,0 after a vertical gap
	task automatic sync_frame_start();
		int len;
		len = 0;
		@(negedge cclk);
		while (len <= 45) begin
			count_level(1'b1, len);
			count_level(1'b0, len);
		end
	endtask

	// every enabled pixel of one frame against the crosshair
	task automatic scan_cursor_frame(input int cx, input int cy, input string label);
		int bad;
		int first_col;
		int first_row;
		int gap;
		logic [23:0] exp_rgb;
		logic [23:0] got_rgb;
		bad = 0;
		first_col = -1;
		first_row = -1;
		sync_frame_start();
		for (int row = 0; row < 272; row++) begin
			for (int col = 0; col < 480; col++) begin
				exp_rgb = (col == cx || row == cy) ? CURSOR_RGB : BG_RGB;
				got_rgb = {tft_red, tft_green, tft_blue};
				if (!tft_data_ena || got_rgb != exp_rgb) begin
					if (bad == 0) begin
						first_col = col;
						first_row = row;
					end
					bad++;
				end
				@(negedge cclk);
			end
			if (row < 271)
				count_level(1'b0, gap);
		end
		expect_true(bad == 0, $sformatf("%s frame: %0d wrong pixels, first at column %0d row %0d",
			label, bad, first_col, first_row));
	endtask

	task automatic register_access();
		int e0;
		logic err;
		logic [31:0] data;
		e0 = errors;
		// idle levels right after reset
		@(negedge cclk);
		expect_true(touch_csb && touch_clk && !tft_data_ena && tft_display && tft_vdd,
			$sformatf("after reset csb %b clk %b ena %b display %b vdd %b",
			touch_csb, touch_clk, tft_data_ena, tft_display, tft_vdd));
		// status first, before the first sample lands
		read_compare(touch_tft_pkg::REG_STATUS, 32'h0, "status after reset");
		write_reg(touch_tft_pkg::REG_STATUS, 32'hFFFF_FFFF, err);
		expect_true(!err, "write to status gave pslverr");
		read_compare(touch_tft_pkg::REG_STATUS, 32'h0, "status after write");
		expect_true(pready, "pready is low");
		read_compare(touch_tft_pkg::REG_CTRL, 32'h1, "ctrl reset");
		read_compare(touch_tft_pkg::REG_BACKLIGHT, 32'h80, "backlight reset");
		read_compare(touch_tft_pkg::REG_CURSOR, 32'hFF_FFFF, "cursor reset");
		read_compare(touch_tft_pkg::REG_BG, 32'h0, "background reset");
		read_compare(touch_tft_pkg::REG_THRESH, 32'd512, "threshold reset");
		write_cfg(touch_tft_pkg::REG_CTRL, 32'h0);
		read_compare(touch_tft_pkg::REG_CTRL, 32'h0, "ctrl cleared");
		write_cfg(touch_tft_pkg::REG_CTRL, 32'h1);
		read_compare(touch_tft_pkg::REG_CTRL, 32'h1, "ctrl set");
		// fields narrower than the bus
		write_cfg(touch_tft_pkg::REG_BACKLIGHT, 32'h1A5);
		read_compare(touch_tft_pkg::REG_BACKLIGHT, 32'hA5, "backlight write");
		write_cfg(touch_tft_pkg::REG_CURSOR, 32'hFF12_3456);
		read_compare(touch_tft_pkg::REG_CURSOR, 32'h12_3456, "cursor write");
		write_cfg(touch_tft_pkg::REG_BG, 32'hAB_CDEF);
		read_compare(touch_tft_pkg::REG_BG, 32'hAB_CDEF, "background write");
		write_cfg(touch_tft_pkg::REG_THRESH, 32'hFABC);
		read_compare(touch_tft_pkg::REG_THRESH, 32'hABC, "threshold write");
		// unmapped offset
		write_reg(8'h1C, 32'h5A5A_5A5A, err);
		expect_true(err, "no pslverr on write to 0x1C");
		read_reg(8'h1C, data, err);
		expect_true(err, "no pslverr on read of 0x1C");
		write_cfg(touch_tft_pkg::REG_THRESH, 32'd512);
		finish_test("registers", e0);
	endtask

	// highs in one full pwm period
	task automatic check_pwm_duty(input int duty);
		int highs;
		write_cfg(touch_tft_pkg::REG_BACKLIGHT, 32'(duty));
		repeat (2) @(posedge cclk);
		highs = 0;
		repeat (256) begin
			@(negedge cclk);
			if (tft_backlight)
				highs++;
		end
		expect_true(highs == duty, $sformatf("backlight high %0d of 256, duty %0d", highs, duty));
	endtask

	task automatic backlight_duty();
		int e0;
		e0 = errors;
		check_pwm_duty(64);
		check_pwm_duty(200);
		finish_test("backlight", e0);
	endtask

	task automatic frame_scan();
		int e0;
		int runs;
		int len;
		int gap;
		e0 = errors;
		runs = 0;
		sync_frame_start();
		do begin
			count_level(1'b1, len);
			runs++;
			expect_true(len == 480, $sformatf("line %0d enable run is %0d cycles", runs, len));
			count_level(1'b0, gap);
			if (gap <= 45)
				expect_true(gap == 45, $sformatf("gap after line %0d is %0d cycles", runs, gap));
		end while (gap <= 45);
		expect_true(runs == 272, $sformatf("%0d enable runs in a frame", runs));
		// 16 blank lines plus the last line's own blank
		expect_true(gap == 16 * 525 + 45, $sformatf("vertical gap is %0d cycles", gap));
		finish_test("frame scan", e0);
	endtask

	task automatic touch_sample_readback();
		int e0;
		int polls;
		logic [31:0] status;
		logic err;
		e0 = errors;
		polls = 0;
		status = '0;
		while (!status[24] && polls < 2000) begin
			read_reg(touch_tft_pkg::REG_STATUS, status, err);
			polls++;
		end
		expect_reached(status[24], "no touch sample was reported in the status register");
		expect_true(status[23:12] == TOUCH_X, $sformatf("status x %h", status[23:12]));
		expect_true(status[11:0] == TOUCH_Y, $sformatf("status y %h", status[11:0]));
		finish_test("touch sample", e0);
	endtask

	task automatic cursor_drawing();
		int e0;
		int polls;
		logic [31:0] status;
		logic err;
		e0 = errors;
		write_cfg(touch_tft_pkg::REG_THRESH, 32'd512);
		write_cfg(touch_tft_pkg::REG_CURSOR, 32'(CURSOR_RGB));
		write_cfg(touch_tft_pkg::REG_BG, 32'(BG_RGB));
		scan_cursor_frame(expected_column(TOUCH_X), expected_row(TOUCH_Y), "pressed");
		// light touch somewhere else
		@(posedge cclk);
		x_val <= MOVED_X;
		y_val <= MOVED_Y;
		z_val <= LIGHT_Z;
		polls = 0;
		status = '0;
		do begin
			read_reg(touch_tft_pkg::REG_STATUS, status, err);
			polls++;
		end while (status[23:0] != {MOVED_X, MOVED_Y} && polls < 2000);
		expect_reached(status[23:0] == {MOVED_X, MOVED_Y},
			"the moved touch position never reached the status register");
		// crosshair held at the pressed position
		scan_cursor_frame(expected_column(TOUCH_X), expected_row(TOUCH_Y), "released");
		finish_test("cursor drawing", e0);
	endtask

	task automatic display_disable();
		int e0;
		int highs;
		e0 = errors;
		write_cfg(touch_tft_pkg::REG_CTRL, 32'h0);
		// enable output lags by one pixel
		repeat (2) @(negedge cclk);
		expect_true(!tft_display && !tft_vdd,
			$sformatf("display %b vdd %b with display off", tft_display, tft_vdd));
		highs = 0;
		repeat (525 * 288) begin
			@(negedge cclk);
			if (tft_data_ena)
				highs++;
		end
		expect_true(highs == 0, $sformatf("data enable high %0d cycles with display off", highs));
		write_cfg(touch_tft_pkg::REG_CTRL, 32'h1);
		@(negedge cclk);
		expect_true(tft_display && tft_vdd, "display and vdd not back on");
		finish_test("display disable", e0);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		tests_run = 0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		// pen held down from power up
		x_val <= TOUCH_X;
		y_val <= TOUCH_Y;
		z_val <= TOUCH_Z;
		reset <= 1'b1;
		repeat (3) @(posedge cclk);
		reset <= 1'b0;
		register_access();
		backlight_duty();
		frame_scan();
		touch_sample_readback();
		cursor_drawing();
		display_disable();
		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: touch_tft.f
rtl/touch_tft_pkg.sv
rtl/touch_sample_if.sv
rtl/touchpad_controller.sv
rtl/tft_timing.sv
rtl/cursor_compositor.sv
rtl/tft_ctrl_regs.sv
rtl/touch_tft_top.sv
dv/touch_panel_model.sv
dv/tb_touch_tft.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_touch_tft -f touch_tft.f -o tb_touch_tft &&
	./obj_dir/tb_touch_tft > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
